//--- reg_bank_top.f
logic/reg_map_pkg.sv
logic/reg_access_if.sv
logic/apb_slave_port.sv
logic/reg_store.sv
logic/reg_bank_top.sv
tests/reg_bank_assert.sv
tests/reg_bank_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = reg_bank_tb
FILELIST = reg_bank_top.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

# the run fails unless the testbench prints the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/reg_bank_tb.sv
`timescale 1ns/100ps
`default_nettype none

module reg_bank_tb import reg_map_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 4;
	localparam int DRIVE_DELAY = 5;     // inputs change this long after a rising edge
	localparam int PREADY_TIMEOUT = 8;  // cycles a transfer may wait for pready
	localparam logic [ADDR_WIDTH-1:0] MISALIGNED_ADDR = 8'h21;
	localparam logic [ADDR_WIDTH-1:0] OUT_OF_RANGE_ADDR = 8'h40;  // word index 16

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [ADDR_WIDTH-1:0] paddr;
	reg_data_t pwdata;
	reg_data_t prdata;
	logic pready;
	logic pslverr;
	logic [REG_COUNT-1:0] rtl_write_reqs;
	logic [REG_COUNT-1:0] rtl_read_reqs;
	logic [REG_COUNT-1:0] rtl_rdy;
	reg_data_t [REG_COUNT-1:0] rtl_wd_in;
	reg_data_t [REG_COUNT-1:0] rtl_rd_out;
	logic [REG_COUNT-1:0] fresh_bits;

	int seed = 32'he360;
	int errors = 0;
	int tests_run = 0;
	reg_data_t model [REG_COUNT];  // what each register should read back as

	reg_bank_top dut (.*);

	bind reg_bank_top reg_bank_assert u_assert (
		.clk        (clk),
		.rst_n      (rst_n),
		.psel       (psel),
		.penable    (penable),
		.pready     (pready),
		.pslverr    (pslverr),
		.wr_en      (bus.wr_en),
		.rd_en      (bus.rd_en),
		.fresh_bits (fresh_bits)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [ADDR_WIDTH-1:0] reg_addr(input reg_id_t id);
		return ADDR_WIDTH'({id, 2'b00});
	endfunction

	task automatic expect_equal(input string what, input reg_data_t got, input reg_data_t exp);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s: got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// outputs are sampled at the falling edge where nothing is changing
	task automatic apb_transfer(input logic write, input logic [ADDR_WIDTH-1:0] addr,
			input reg_data_t wdata, output reg_data_t rdata, output logic err);
		int waited;
		int exp_waits;
		// only a good read gets a wait state
		exp_waits = (write || addr[1:0] != 2'b00 || addr[ADDR_WIDTH-1:2] >= REG_COUNT) ? 0 : 1;
		@(posedge clk);
		#DRIVE_DELAY;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#DRIVE_DELAY;
		penable = 1'b1;
		@(negedge clk);
		waited = 0;
		while (!pready && waited < PREADY_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!pready) begin
			$display("APB transfer to address %h never got pready", addr);
			errors++;
		end else if (waited != exp_waits) begin
			$display("[FAIL] %0t: wait states at address %h: got %0d, expected %0d",
				$time, addr, waited, exp_waits);
			errors++;
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		#DRIVE_DELAY;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [ADDR_WIDTH-1:0] addr, input reg_data_t data,
			output logic err);
		reg_data_t ignored;
		apb_transfer(1'b1, addr, data, ignored, err);
	endtask

	task automatic apb_read(input logic [ADDR_WIDTH-1:0] addr, output reg_data_t data,
			output logic err);
		apb_transfer(1'b0, addr, '0, data, err);
	endtask

	task automatic write_reg(input reg_id_t id, input reg_data_t data);
		logic err;
		apb_write(reg_addr(id), data, err);
		expect_equal($sformatf("pslverr on write to register %0d", id), err, 1'b0);
	endtask

	task automatic check_reg(input reg_id_t id, input reg_data_t exp);
		reg_data_t data;
		logic err;
		apb_read(reg_addr(id), data, err);
		expect_equal($sformatf("pslverr on read of register %0d", id), err, 1'b0);
		expect_equal($sformatf("read of register %0d", id), data, exp);
	endtask

	// drives one logic-side lane for one cycle and returns after the edge that acts on it
	task automatic logic_write(input reg_id_t id, input reg_data_t data);
		@(posedge clk);
		#DRIVE_DELAY;
		rtl_write_reqs[id] = 1'b1;
		rtl_wd_in[id] = data;
		@(posedge clk);
		#DRIVE_DELAY;
		rtl_write_reqs[id] = 1'b0;
	endtask

	task automatic logic_read(input reg_id_t id, input logic poll, output reg_data_t data);
		@(posedge clk);
		#DRIVE_DELAY;
		rtl_rdy[id] = poll;
		rtl_read_reqs[id] = !poll;
		@(posedge clk);
		#DRIVE_DELAY;
		rtl_rdy[id] = 1'b0;
		rtl_read_reqs[id] = 1'b0;
		data = rtl_rd_out[id];
	endtask

	task automatic finish_test(input string name, input int start);
		tests_run++;
		$display("test %s finished with %0d errors", name, errors - start);
	endtask

	task automatic test_constants();
		int start;
		start = errors;
		for (int i = VERSION_ID; i <= MAX_BURST_SIZE_ID; i++) begin
			check_reg(reg_id_t'(i), model[i]);
			write_reg(reg_id_t'(i), 16'hbeef);  // OKAY but ignored
			logic_write(reg_id_t'(i), 16'h5a5a);
			check_reg(reg_id_t'(i), model[i]);
		end
		finish_test("constants", start);
	endtask

	task automatic test_write_read();
		int start;
		start = errors;
		for (int i = 8; i < REG_COUNT; i++) begin
			model[i] = reg_data_t'($random(seed));
			write_reg(reg_id_t'(i), model[i]);
		end
		for (int i = 8; i < REG_COUNT; i++)
			check_reg(reg_id_t'(i), model[i]);
		write_reg(ILA_BURST_SIZE_ID, 16'd300);
		check_reg(ILA_BURST_SIZE_ID, MAX_ILA_BURST_SIZE);
		write_reg(SCALE_DAC_OUT_ID, 16'hffff);
		check_reg(SCALE_DAC_OUT_ID, MAX_SCALE_FACTOR);
		model[ILA_BURST_SIZE_ID] = 16'd100;
		model[SCALE_DAC_OUT_ID] = 16'd999;
		write_reg(ILA_BURST_SIZE_ID, model[ILA_BURST_SIZE_ID]);
		write_reg(SCALE_DAC_OUT_ID, model[SCALE_DAC_OUT_ID]);
		check_reg(ILA_BURST_SIZE_ID, model[ILA_BURST_SIZE_ID]);
		check_reg(SCALE_DAC_OUT_ID, model[SCALE_DAC_OUT_ID]);
		finish_test("write_read", start);
	endtask

	task automatic test_fresh();
		int start;
		reg_data_t got;
		start = errors;
		model[9] = reg_data_t'($random(seed));
		write_reg(4'd9, model[9]);
		expect_equal("fresh after processor write", fresh_bits[9], 1'b1);
		logic_read(4'd9, 1'b0, got);
		expect_equal("logic read", got, model[9]);
		expect_equal("fresh after logic read", fresh_bits[9], 1'b0);
		model[9] = ~model[9];
		logic_write(4'd9, model[9]);
		expect_equal("fresh after logic write", fresh_bits[9], 1'b1);
		check_reg(4'd9, model[9]);
		expect_equal("fresh after processor read", fresh_bits[9], 1'b0);
		finish_test("fresh", start);
	endtask

	task automatic test_collision();
		int start;
		reg_data_t old_data;
		start = errors;
		model[10] = reg_data_t'($random(seed));
		@(posedge clk);
		#DRIVE_DELAY;
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = reg_addr(4'd10);
		pwdata = model[10];
		@(posedge clk);
		#DRIVE_DELAY;
		penable = 1'b1;
		rtl_write_reqs[10] = 1'b1;  // logic writes in the processor's access cycle
		rtl_wd_in[10] = ~model[10];
		@(negedge clk);
		if (!pready) begin
			$display("APB write to register 10 did not finish in its first access cycle");
			errors++;
		end
		@(posedge clk);
		#DRIVE_DELAY;
		psel = 1'b0;
		penable = 1'b0;
		rtl_write_reqs[10] = 1'b0;
		check_reg(4'd10, model[10]);
		old_data = model[11];
		model[11] = ~old_data;
		@(posedge clk);
		#DRIVE_DELAY;
		rtl_write_reqs[11] = 1'b1;
		rtl_wd_in[11] = model[11];
		rtl_read_reqs[11] = 1'b1;
		@(posedge clk);
		#DRIVE_DELAY;
		rtl_write_reqs[11] = 1'b0;  // the read request stays up for the next cycle
		expect_equal("same-cycle logic read", rtl_rd_out[11], old_data);
		expect_equal("fresh kept by same-cycle write", fresh_bits[11], 1'b1);
		@(posedge clk);
		#DRIVE_DELAY;
		rtl_read_reqs[11] = 1'b0;
		expect_equal("logic read in the next cycle", rtl_rd_out[11], model[11]);
		finish_test("collision", start);
	endtask

	task automatic test_poll();
		int start;
		reg_data_t got;
		start = errors;
		for (int i = POLL_FIRST_ID; i <= POLL_LAST_ID; i++) begin
			logic_write(reg_id_t'(i), 16'hdead);
			check_reg(reg_id_t'(i), model[i]);
			model[i] = reg_data_t'($random(seed));
			write_reg(reg_id_t'(i), model[i]);
			expect_equal("poll fresh after write", fresh_bits[i], 1'b1);
			logic_read(reg_id_t'(i), 1'b1, got);
			expect_equal("poll value on rtl_rd_out", got, model[i]);
			expect_equal("poll fresh after rtl_rdy", fresh_bits[i], 1'b0);
		end
		finish_test("poll", start);
	endtask

	task automatic test_errors();
		int start;
		logic [ADDR_WIDTH-1:0] addr;
		reg_data_t data;
		logic err;
		start = errors;
		for (int i = 0; i < 2; i++) begin
			addr = (i == 0) ? MISALIGNED_ADDR : OUT_OF_RANGE_ADDR;
			apb_write(addr, 16'h1234, err);
			expect_equal("pslverr on bad write", err, 1'b1);
			apb_read(addr, data, err);
			expect_equal("pslverr on bad read", err, 1'b1);
		end
		for (int i = 0; i < REG_COUNT; i++)
			check_reg(reg_id_t'(i), model[i]);
		finish_test("errors", start);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rtl_write_reqs = '0;
		rtl_read_reqs = '0;
		rtl_rdy = '0;
		rtl_wd_in = '0;
		for (int i = 0; i < REG_COUNT; i++)
			model[i] = '0;
		model[VERSION_ID] = FIRMWARE_VERSION;
		model[MEM_SIZE_ID] = reg_data_t'(REG_COUNT);
		model[MAX_BURST_SIZE_ID] = MAX_ILA_BURST_SIZE;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		test_constants();
		test_write_read();
		test_fresh();
		test_collision();
		test_poll();
		test_errors();
		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/reg_bank_assert.sv
`timescale 1ns/100ps
`default_nettype none

// bus protocol and fresh-bit rules, bound onto the register bank top level
module reg_bank_assert import reg_map_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire psel,
	input wire penable,
	input wire pready,
	input wire pslverr,
	input wire wr_en,  // decoded requests between the port and the store
	input wire rd_en,
	input wire [REG_COUNT-1:0] fresh_bits
);

	// the completer only answers inside an access cycle
	pready_in_access: assert property (
		@(posedge clk) disable iff (!rst_n) pready |-> (psel && penable)
	) else $error("pready high outside an access cycle");

	pslverr_with_pready: assert property (
		@(posedge clk) disable iff (!rst_n) pslverr |-> pready
	) else $error("pslverr high without pready");

	one_request: assert property (
		@(posedge clk) disable iff (!rst_n) !(wr_en && rd_en)
	) else $error("write and read request to the store in the same cycle");

	// constants hold no data that could be fresh
	const_not_fresh: assert property (
		@(posedge clk) disable iff (!rst_n) fresh_bits[MAX_BURST_SIZE_ID:VERSION_ID] == '0
	) else $error("fresh bit set on a constant register");

endmodule

`default_nettype wire

//--- logic/reg_bank_top.sv
`timescale 1ns/100ps
`default_nettype none

// register bank shared by an APB master and on-chip logic
module reg_bank_top import reg_map_pkg::*; (
	input wire clk,
	input wire rst_n,

	// APB completer
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [ADDR_WIDTH-1:0] paddr,
	input wire reg_data_t pwdata,
	output reg_data_t prdata,
	output logic pready,
	output logic pslverr,

	// logic side, one lane per register
	input wire [REG_COUNT-1:0] rtl_write_reqs,
	input wire [REG_COUNT-1:0] rtl_read_reqs,
	input wire [REG_COUNT-1:0] rtl_rdy,
	input wire reg_data_t [REG_COUNT-1:0] rtl_wd_in,
	output reg_data_t [REG_COUNT-1:0] rtl_rd_out,
	output logic [REG_COUNT-1:0] fresh_bits  // set while the other side has unread data
);

	reg_access_if bus ();

	apb_slave_port u_apb_port (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.bus     (bus)
	);

	// holds the array, arbitration and fresh tracking
	reg_store u_store (
		.clk            (clk),
		.rst_n          (rst_n),
		.rtl_write_reqs (rtl_write_reqs),
		.rtl_read_reqs  (rtl_read_reqs),
		.rtl_rdy        (rtl_rdy),
		.rtl_wd_in      (rtl_wd_in),
		.rtl_rd_out     (rtl_rd_out),
		.fresh_bits     (fresh_bits),
		.bus            (bus)
	);

endmodule

`default_nettype wire

//--- logic/reg_store.sv
`timescale 1ns/100ps
`default_nettype none

module reg_store import reg_map_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire [REG_COUNT-1:0] rtl_write_reqs,   // one request bit per register
	input wire [REG_COUNT-1:0] rtl_read_reqs,
	input wire [REG_COUNT-1:0] rtl_rdy,          // only meaningful on poll registers
	input wire reg_data_t [REG_COUNT-1:0] rtl_wd_in,
	output reg_data_t [REG_COUNT-1:0] rtl_rd_out,
	output logic [REG_COUNT-1:0] fresh_bits,
	reg_access_if.store bus
);

	reg_data_t regs [REG_COUNT];
	reg_data_t cur_val [REG_COUNT];  // what each register reads as before this edge
	reg_data_t ps_val [REG_COUNT];   // processor data after clamping

	logic [REG_COUNT-1:0] ps_wr;
	logic [REG_COUNT-1:0] rtl_wr;
	logic [REG_COUNT-1:0] ps_rd;
	logic [REG_COUNT-1:0] rtl_take;
	logic [REG_COUNT-1:0] fresh_clr;
	logic [REG_COUNT-1:0] ps_wrote_last;  // 1 when the processor was the last writer

	function automatic reg_data_t const_value(input int idx);
		case (idx)
			VERSION_ID: return FIRMWARE_VERSION;
			MEM_SIZE_ID: return reg_data_t'(REG_COUNT);
			MAX_BURST_SIZE_ID: return MAX_ILA_BURST_SIZE;
			default: return '0;
		endcase
	endfunction

	always_comb begin
		for (int i = 0; i < REG_COUNT; i++) begin
			if (REG_KINDS[i] == kind_const)
				cur_val[i] = const_value(i);  // constants are never stored
			else
				cur_val[i] = regs[i];

			if (REG_KINDS[i] == kind_clamp && bus.wdata > CLAMP_LIMITS[i])
				ps_val[i] = CLAMP_LIMITS[i];
			else
				ps_val[i] = bus.wdata;

			// writes to constants are accepted on the bus but go nowhere
			ps_wr[i] = bus.wr_en && bus.id == reg_id_t'(i) && REG_KINDS[i] != kind_const;
			ps_rd[i] = bus.rd_en && bus.id == reg_id_t'(i);

			// the logic may write clamped and general registers only
			rtl_wr[i] = rtl_write_reqs[i] &&
				(REG_KINDS[i] == kind_clamp || REG_KINDS[i] == kind_general);

			// poll registers are taken with rtl_rdy, all others with a read request
			if (REG_KINDS[i] == kind_poll)
				rtl_take[i] = rtl_rdy[i];
			else
				rtl_take[i] = rtl_read_reqs[i];

			// a read by the side that did not write last consumes the data
			fresh_clr[i] = (rtl_take[i] && ps_wrote_last[i]) ||
				(ps_rd[i] && !ps_wrote_last[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < REG_COUNT; i++) begin
				if (ps_wr[i])
					regs[i] <= ps_val[i];  // processor wins a same-cycle collision
				else if (rtl_wr[i])
					regs[i] <= rtl_wd_in[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fresh_bits <= '0;
			ps_wrote_last <= '0;
		end else begin
			for (int i = 0; i < REG_COUNT; i++) begin
				// a write in the same cycle as a clearing read keeps the bit set
				if (ps_wr[i]) begin
					fresh_bits[i] <= 1'b1;
					ps_wrote_last[i] <= 1'b1;
				end else if (rtl_wr[i]) begin
					fresh_bits[i] <= 1'b1;
					ps_wrote_last[i] <= 1'b0;
				end else if (fresh_clr[i]) begin
					fresh_bits[i] <= 1'b0;
				end
			end
		end
	end

	// logic side reads see the value from before any write on the same edge
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rtl_rd_out <= '0;
		end else begin
			for (int i = 0; i < REG_COUNT; i++) begin
				if (rtl_take[i])
					rtl_rd_out[i] <= cur_val[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus.rd_en)
			bus.rdata <= cur_val[bus.id];  // the port holds prdata at zero until this is valid
	end

endmodule

`default_nettype wire

//--- logic/apb_slave_port.sv
`timescale 1ns/100ps
`default_nettype none

module apb_slave_port import reg_map_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [ADDR_WIDTH-1:0] paddr,
	input wire reg_data_t pwdata,
	output reg_data_t prdata,
	output logic pready,
	output logic pslverr,
	reg_access_if.requester bus
);

	// a read steps through read_wait and read_done while writes and errors stay in idle
	typedef enum logic [1:0] {
		st_idle,
		st_read_wait,
		st_read_done
	} phase_t;

	phase_t state;
	phase_t next_state;
	logic [ADDR_WIDTH-3:0] word_idx;
	logic aligned;
	logic in_range;
	logic addr_ok;
	logic setup;
	logic access;

	assign word_idx = paddr[ADDR_WIDTH-1:2];
	assign aligned = paddr[1:0] == 2'b00;
	assign in_range = word_idx < REG_COUNT;
	assign addr_ok = aligned && in_range;

	assign setup = psel && !penable;
	assign access = psel && penable;

	assign bus.id = paddr[ID_WIDTH+1:2];
	assign bus.wdata = pwdata;

	// a bad address never turns into a store request
	assign bus.wr_en = access && pwrite && addr_ok && state == st_idle;
	assign bus.rd_en = access && state == st_read_wait;

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				// a good read is recognised in its setup cycle so rd_en lands in the first access
				if (setup && !pwrite && addr_ok)
					next_state = st_read_wait;
			end
			st_read_wait: begin
				next_state = access ? st_read_done : st_idle;  // drop out if the requester gave up
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= st_idle;
		else
			state <= next_state;
	end

	always_comb begin
		pready = 1'b0;
		pslverr = 1'b0;
		prdata = '0;
		if (access) begin
			if (state == st_idle) begin
				// writes and errored transfers of either direction finish right away
				pready = pwrite || !addr_ok;
				pslverr = !addr_ok;
			end else if (state == st_read_done) begin
				pready = 1'b1;
				prdata = bus.rdata;  // registered by the store on the previous edge
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/reg_access_if.sv
`timescale 1ns/100ps
`default_nettype none

// decoded register requests from the bus port into the register store
interface reg_access_if import reg_map_pkg::*; ();

	logic wr_en;       // one cycle, in the write's access cycle
	logic rd_en;       // one cycle, in the read's first access cycle
	reg_id_t id;
	reg_data_t wdata;
	reg_data_t rdata;  // valid the cycle after rd_en

	modport requester (
		output wr_en,
		output rd_en,
		output id,
		output wdata,
		input  rdata
	);

	modport store (
		input  wr_en,
		input  rd_en,
		input  id,
		input  wdata,
		output rdata
	);

endinterface

`default_nettype wire

//--- logic/reg_map_pkg.sv
`default_nettype none

package reg_map_pkg;

	localparam int DATA_WIDTH = 16;
	localparam int ADDR_WIDTH = 8;  // byte address, each register sits at four times its id
	localparam int REG_COUNT = 16;
	localparam int ID_WIDTH = $clog2(REG_COUNT);

	typedef logic [DATA_WIDTH-1:0] reg_data_t;
	typedef logic [ID_WIDTH-1:0] reg_id_t;

	// how a register behaves towards the two sides
	typedef enum logic [1:0] {
		kind_const,
		kind_clamp,
		kind_poll,
		kind_general
	} reg_kind_t;

	// read-only constants
	localparam reg_id_t VERSION_ID = 4'd0;
	localparam reg_id_t MEM_SIZE_ID = 4'd1;
	localparam reg_id_t MAX_BURST_SIZE_ID = 4'd2;

	// processor writes to these are limited to the values below
	localparam reg_id_t ILA_BURST_SIZE_ID = 4'd3;
	localparam reg_id_t SCALE_DAC_OUT_ID = 4'd4;

	// the logic picks these up with rtl_rdy and cannot write them
	localparam reg_id_t POLL_FIRST_ID = 4'd5;
	localparam reg_id_t POLL_LAST_ID = 4'd7;

	localparam reg_data_t FIRMWARE_VERSION = 16'h0103;
	localparam reg_data_t MAX_ILA_BURST_SIZE = 16'd256;
	localparam reg_data_t MAX_SCALE_FACTOR = 16'd1000;

	// everything not listed here is a general register shared by both sides
	localparam reg_kind_t [0:REG_COUNT-1] REG_KINDS = '{
		VERSION_ID:        kind_const,
		MEM_SIZE_ID:       kind_const,
		MAX_BURST_SIZE_ID: kind_const,
		ILA_BURST_SIZE_ID: kind_clamp,
		SCALE_DAC_OUT_ID:  kind_clamp,
		POLL_FIRST_ID:     kind_poll,
		4'd6:              kind_poll,
		POLL_LAST_ID:      kind_poll,
		default:           kind_general
	};

	// zero where a register has no limit
	localparam reg_data_t [0:REG_COUNT-1] CLAMP_LIMITS = '{
		ILA_BURST_SIZE_ID: MAX_ILA_BURST_SIZE,
		SCALE_DAC_OUT_ID:  MAX_SCALE_FACTOR,
		default:           16'd0
	};

endpackage

`default_nettype wire
